/* ilk_avl_pkg.sv */
// shared typedefs, end-of-packet code constants and framing state enum
package ilk_avl_pkg;

   // interlaken end-of-packet code as carried next to each beat
   typedef logic [3:0] eopbits_t;

   // statistics counter, wraps at 2^32
   typedef logic [31:0] count_t;

   // packet continues, no end in this beat
   localparam eopbits_t EOP_NONE = 4'b0000;

   // end of packet, packet is bad
   localparam eopbits_t EOP_ERR  = 4'b0001;

   // end of packet, low three bits give bytes valid in last word (0 = all 8)
   localparam eopbits_t EOP_FLAG = 4'b1000;

   // bytes per 64-bit word, used for the empty count
   localparam int unsigned BYTES_PER_WORD = 8;

   // framing stage state
   typedef enum logic {
      FRAME_IDLE,   // waiting for sop
      FRAME_IN_PKT  // between sop and eop
   } frame_state_t;

endpackage

/* ilk_eop_decoder.sv */
// ilk_eop_decoder: word count and eop code to avalon valid, eop, empty and error
module ilk_eop_decoder #(
   parameter int WORDS     = 2,
   parameter int LOG_WORDS = 2   // wide enough to hold WORDS
) (
   input  logic                       ilk_valid,
   input  logic [LOG_WORDS-1:0]       ilk_num_valid,  // number of valid 64-bit words
   input  ilk_avl_pkg::eopbits_t      ilk_eopbits,    // eop, empty and error encoded here
   output logic                       dec_valid,
   output logic                       dec_eop,
   output logic                       dec_error,
   output logic [LOG_WORDS+1:0]       dec_empty       // empty bytes in the whole beat
);

   localparam int EMPTY_W = LOG_WORDS + 2;

   // word count of a full beat, at the width of the empty field
   localparam logic [EMPTY_W-1:0] WORDS_E = EMPTY_W'(WORDS);

   logic [EMPTY_W-1:0] count_e;     // zero-extended word count
   logic               count_ok;    // count between 1 and WORDS
   logic [EMPTY_W-1:0] base_empty;  // bytes of the unused words
   logic [EMPTY_W-1:0] tail_empty;  // unused bytes in the last valid word
   logic [2:0]         last_bytes;  // low bits of a flagged code
   logic               eop_flagged; // flag bit set in the code

   assign count_e     = {2'b00, ilk_num_valid};
   assign count_ok    = (ilk_num_valid != '0) && (count_e <= WORDS_E);
   assign last_bytes  = ilk_eopbits[2:0];
   assign eop_flagged = (ilk_eopbits & ilk_avl_pkg::EOP_FLAG) != '0;

   // (WORDS - count) * bytes per word, shifted since a word has 8 bytes
   assign base_empty = (WORDS_E - count_e) << 3;

   // 0 in the low bits means the last word is full
   always_comb begin
      if (last_bytes == 3'd0) begin
         tail_empty = '0;
      end else begin
         tail_empty = EMPTY_W'(ilk_avl_pkg::BYTES_PER_WORD - int'(last_bytes));
      end
   end

   always_comb begin
      // idle or malformed count: everything low
      dec_valid = 1'b0;
      dec_eop   = 1'b0;
      dec_error = 1'b0;
      dec_empty = '0;
      if (ilk_valid && count_ok) begin
         dec_valid = 1'b1;
         if (ilk_eopbits == ilk_avl_pkg::EOP_NONE) begin
            dec_empty = base_empty;                // mid-packet beat, unused words only
         end else if (ilk_eopbits == ilk_avl_pkg::EOP_ERR) begin
            dec_eop   = 1'b1;                      // errored end, empty meaningless
            dec_error = 1'b1;
         end else if (eop_flagged) begin
            dec_eop   = 1'b1;                      // good end of packet
            dec_empty = base_empty + tail_empty;
         end else begin
            // codes 2..7 are undefined, close the packet as bad
            dec_eop   = 1'b1;
            dec_error = 1'b1;
         end
      end
   end

endmodule

/* avl_frame_check.sv */
// avl_frame_check: registered avalon output stage with orphan drop and restart detect
module avl_frame_check #(
   parameter int WORDS     = 2,
   parameter int LOG_WORDS = 2
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 dec_valid,
   input  logic                 dec_eop,
   input  logic                 dec_error,
   input  logic [LOG_WORDS+1:0] dec_empty,
   input  logic                 ilk_sop,
   input  logic [WORDS*64-1:0]  ilk_data,
   output logic [WORDS*64-1:0]  avl_data,
   output logic                 avl_sop,
   output logic                 avl_eop,
   output logic                 avl_valid,
   output logic                 avl_error,
   output logic [LOG_WORDS+1:0] avl_empty,
   output logic                 drop_pulse,   // orphan beat discarded
   output logic                 trunc_pulse   // sop seen inside an open packet
);

   ilk_avl_pkg::frame_state_t state_q;
   ilk_avl_pkg::frame_state_t state_d;

   logic in_pkt;    // current state is FRAME_IN_PKT
   logic accept;    // beat goes to the avalon side
   logic orphan;    // valid beat with no packet open
   logic restart;   // new sop before the previous eop

   assign in_pkt  = (state_q == ilk_avl_pkg::FRAME_IN_PKT);
   assign accept  = dec_valid && (in_pkt || ilk_sop);
   assign orphan  = dec_valid && !in_pkt && !ilk_sop;
   assign restart = dec_valid && in_pkt && ilk_sop;

   // next state only moves on beats that are passed on
   always_comb begin
      state_d = state_q;
      if (accept) begin
         if (dec_eop) begin
            state_d = ilk_avl_pkg::FRAME_IDLE;     // single-beat packets land here too
         end else begin
            state_d = ilk_avl_pkg::FRAME_IN_PKT;
         end
      end
   end

   // control and strobes
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q     <= ilk_avl_pkg::FRAME_IDLE;
         avl_valid   <= 1'b0;
         avl_sop     <= 1'b0;
         avl_eop     <= 1'b0;
         avl_error   <= 1'b0;
         drop_pulse  <= 1'b0;
         trunc_pulse <= 1'b0;
      end else begin
         state_q     <= state_d;
         avl_valid   <= accept;
         avl_sop     <= accept && ilk_sop;    // qualified, low between beats
         avl_eop     <= accept && dec_eop;
         avl_error   <= accept && dec_error;
         drop_pulse  <= orphan;
         trunc_pulse <= restart;              // the restarted beat still passes
      end
   end

   // payload, held between beats
   always_ff @(posedge clk) begin
      if (accept) begin
         avl_data  <= ilk_data;
         avl_empty <= dec_empty;
      end
   end

endmodule

/* ilk_rx_stats.sv */
// ilk_rx_stats: packet, errored packet, dropped beat and truncation counters
module ilk_rx_stats (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                avl_valid,
   input  logic                avl_eop,
   input  logic                avl_error,
   input  logic                drop_pulse,
   input  logic                trunc_pulse,
   output ilk_avl_pkg::count_t pkt_count,    // packets closed on the avalon side
   output ilk_avl_pkg::count_t err_count,    // of those, closed with error
   output ilk_avl_pkg::count_t drop_count,   // orphan beats thrown away
   output ilk_avl_pkg::count_t trunc_count   // packets cut short by a new sop
);

   logic pkt_end;   // eop beat leaving the framing stage
   logic pkt_bad;   // same beat flagged bad

   assign pkt_end = avl_valid && avl_eop;
   assign pkt_bad = pkt_end && avl_error;

   // all counters wrap silently
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_count   <= '0;
         err_count   <= '0;
         drop_count  <= '0;
         trunc_count <= '0;
      end else begin
         if (pkt_end) begin
            pkt_count <= pkt_count + 1'b1;
         end
         if (pkt_bad) begin
            err_count <= err_count + 1'b1;
         end
         if (drop_pulse) begin
            drop_count <= drop_count + 1'b1;
         end
         if (trunc_pulse) begin
            trunc_count <= trunc_count + 1'b1;   // one per restart
         end
      end
   end

endmodule

/* ilk_rx_avalon_top.sv */
// ilk_rx_avalon_top: interlaken rx to avalon-st bridge with framing and statistics
module ilk_rx_avalon_top #(
   parameter int WORDS     = 2,
   parameter int LOG_WORDS = 2
) (
   input  logic                  clk,
   input  logic                  arst_n,
   // interlaken side
   input  logic                  ilk_valid,
   input  logic [WORDS*64-1:0]   ilk_data,
   input  logic [LOG_WORDS-1:0]  ilk_num_valid,
   input  logic                  ilk_sop,
   input  ilk_avl_pkg::eopbits_t ilk_eopbits,
   // avalon side, no ready
   output logic [WORDS*64-1:0]   avl_data,
   output logic                  avl_sop,
   output logic                  avl_eop,
   output logic                  avl_valid,
   output logic [LOG_WORDS+1:0]  avl_empty,
   output logic                  avl_error,
   // statistics
   output ilk_avl_pkg::count_t   pkt_count,
   output ilk_avl_pkg::count_t   err_count,
   output ilk_avl_pkg::count_t   drop_count,
   output ilk_avl_pkg::count_t   trunc_count
);

   logic                 dec_valid;
   logic                 dec_eop;
   logic                 dec_error;
   logic [LOG_WORDS+1:0] dec_empty;
   logic                 drop_pulse;
   logic                 trunc_pulse;

   ilk_eop_decoder #(.WORDS(WORDS), .LOG_WORDS(LOG_WORDS)) decoder_i (
      .ilk_valid     (ilk_valid),
      .ilk_num_valid (ilk_num_valid),
      .ilk_eopbits   (ilk_eopbits),
      .dec_valid     (dec_valid),
      .dec_eop       (dec_eop),
      .dec_error     (dec_error),
      .dec_empty     (dec_empty)
   );

   avl_frame_check #(.WORDS(WORDS), .LOG_WORDS(LOG_WORDS)) frame_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .dec_valid   (dec_valid),
      .dec_eop     (dec_eop),
      .dec_error   (dec_error),
      .dec_empty   (dec_empty),
      .ilk_sop     (ilk_sop),       // sop and data bypass the decoder
      .ilk_data    (ilk_data),
      .avl_data    (avl_data),
      .avl_sop     (avl_sop),
      .avl_eop     (avl_eop),
      .avl_valid   (avl_valid),
      .avl_error   (avl_error),
      .avl_empty   (avl_empty),
      .drop_pulse  (drop_pulse),
      .trunc_pulse (trunc_pulse)
   );

   ilk_rx_stats stats_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .avl_valid   (avl_valid),
      .avl_eop     (avl_eop),
      .avl_error   (avl_error),
      .drop_pulse  (drop_pulse),
      .trunc_pulse (trunc_pulse),
      .pkt_count   (pkt_count),
      .err_count   (err_count),
      .drop_count  (drop_count),
      .trunc_count (trunc_count)
   );

endmodule

/* ilk_rx_avalon_asserts.sv */
// bound checker module with the decode and framing reference model, its assertions and the bind
module ilk_rx_avalon_asserts #(
   parameter int WORDS     = 2,
   parameter int LOG_WORDS = 2
) (
   input logic                  clk,
   input logic                  arst_n,
   input logic                  ilk_valid,
   input logic [WORDS*64-1:0]   ilk_data,
   input logic [LOG_WORDS-1:0]  ilk_num_valid,
   input logic                  ilk_sop,
   input ilk_avl_pkg::eopbits_t ilk_eopbits,
   input logic [WORDS*64-1:0]   avl_data,
   input logic                  avl_sop,
   input logic                  avl_eop,
   input logic                  avl_valid,
   input logic [LOG_WORDS+1:0]  avl_empty,
   input logic                  avl_error,
   input ilk_avl_pkg::count_t   drop_count,
   input ilk_avl_pkg::count_t   trunc_count
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int EW = LOG_WORDS + 2;

   int            word_cnt;      // count as an int
   int            low_bytes;     // bytes valid in the last word of a flagged code
   logic          beat_ok;       // valid strobe with a legal count
   logic          exp_eop;
   logic          exp_err;
   logic [EW-1:0] exp_empty;
   logic          exp_accept;    // beat should reach the avalon side
   logic          exp_drop;
   logic          exp_trunc;
   logic          model_in_pkt;  // reference framing state
   int unsigned   fail_count = 0;  // read by the testbench

   always_comb begin
      word_cnt  = int'(ilk_num_valid);
      low_bytes = int'(ilk_eopbits[2:0]);
      beat_ok   = ilk_valid && (word_cnt >= 1) && (word_cnt <= WORDS);
      exp_eop   = beat_ok && (ilk_eopbits != ilk_avl_pkg::EOP_NONE);
      exp_err   = exp_eop && ((ilk_eopbits & ilk_avl_pkg::EOP_FLAG) == 4'h0);  // error and junk codes
      if (!beat_ok || exp_err) begin
         exp_empty = '0;
      end else if (ilk_eopbits[3] && (low_bytes != 0)) begin
         exp_empty = EW'((WORDS - word_cnt) * 8 + 8 - low_bytes);
      end else begin
         exp_empty = EW'((WORDS - word_cnt) * 8);  // whole words only
      end
      exp_accept = beat_ok && (model_in_pkt || ilk_sop);
      exp_drop   = beat_ok && !model_in_pkt && !ilk_sop;
      exp_trunc  = beat_ok && model_in_pkt && ilk_sop;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         model_in_pkt <= 1'b0;
      end else if (exp_accept) begin
         model_in_pkt <= !exp_eop;  // eop closes the packet and any other beat keeps it open
      end
   end

   a_valid: assert property (@(posedge clk) disable iff (!arst_n)
      avl_valid == $past(exp_accept))
      else begin
         fail_count++;
         $error("[FAIL] %0t: avl_valid expected %0b, got %0b", $time,
                $past(exp_accept), $sampled(avl_valid));
      end

   a_eop: assert property (@(posedge clk) disable iff (!arst_n)
      avl_eop == $past(exp_accept && exp_eop))
      else begin
         fail_count++;
         $error("[FAIL] %0t: avl_eop expected %0b, got %0b", $time,
                $past(exp_accept && exp_eop), $sampled(avl_eop));
      end

   a_error: assert property (@(posedge clk) disable iff (!arst_n)
      avl_error == $past(exp_accept && exp_err))
      else begin
         fail_count++;
         $error("[FAIL] %0t: avl_error expected %0b, got %0b", $time,
                $past(exp_accept && exp_err), $sampled(avl_error));
      end

   // payload only means something on valid beats
   a_sop: assert property (@(posedge clk) disable iff (!arst_n)
      avl_valid |-> (avl_sop == $past(ilk_sop)))
      else begin
         fail_count++;
         $error("[FAIL] %0t: avl_sop expected %0b, got %0b", $time,
                $past(ilk_sop), $sampled(avl_sop));
      end

   a_data: assert property (@(posedge clk) disable iff (!arst_n)
      avl_valid |-> (avl_data == $past(ilk_data)))
      else begin
         fail_count++;
         $error("[FAIL] %0t: avl_data expected %h, got %h", $time,
                $past(ilk_data), $sampled(avl_data));
      end

   a_empty: assert property (@(posedge clk) disable iff (!arst_n)
      avl_valid |-> (avl_empty == $past(exp_empty)))
      else begin
         fail_count++;
         $error("[FAIL] %0t: avl_empty expected %0d, got %0d", $time,
                $past(exp_empty), $sampled(avl_empty));
      end

   // counters lag the input beat by two edges
   a_drop: assert property (@(posedge clk) disable iff (!arst_n)
      drop_count == $past(drop_count) + 32'($past(exp_drop, 2)))
      else begin
         fail_count++;
         $error("[FAIL] %0t: drop_count expected %0d, got %0d", $time,
                $past(drop_count) + 32'($past(exp_drop, 2)), $sampled(drop_count));
      end

   a_trunc: assert property (@(posedge clk) disable iff (!arst_n)
      trunc_count == $past(trunc_count) + 32'($past(exp_trunc, 2)))
      else begin
         fail_count++;
         $error("[FAIL] %0t: trunc_count expected %0d, got %0d", $time,
                $past(trunc_count) + 32'($past(exp_trunc, 2)), $sampled(trunc_count));
      end

endmodule

bind ilk_rx_avalon_top ilk_rx_avalon_asserts #(.WORDS(WORDS), .LOG_WORDS(LOG_WORDS)) asserts_i (.*);

/* tb_ilk_rx_avalon.sv */
// testbench: clock, reset, directed and random beats, per-test lines and final verdict
module tb_ilk_rx_avalon;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WORDS     = 2;
   localparam int LOG_WORDS = 2;
   localparam int LIMIT     = 200;  // max cycles for any wait

   logic                  clk = 1'b0;
   logic                  arst_n;
   logic                  ilk_valid;
   logic [WORDS*64-1:0]   ilk_data;
   logic [LOG_WORDS-1:0]  ilk_num_valid;
   logic                  ilk_sop;
   ilk_avl_pkg::eopbits_t ilk_eopbits;
   logic [WORDS*64-1:0]   avl_data;
   logic                  avl_sop;
   logic                  avl_eop;
   logic                  avl_valid;
   logic [LOG_WORDS+1:0]  avl_empty;
   logic                  avl_error;
   ilk_avl_pkg::count_t   pkt_count;
   ilk_avl_pkg::count_t   err_count;
   ilk_avl_pkg::count_t   drop_count;
   ilk_avl_pkg::count_t   trunc_count;

   integer seed = 12871;
   int     tb_errors = 0;    // direct check failures
   int     tests_run = 0;
   int     tests_failed = 0;
   int     errs_at_start = 0;

   always #5 clk = ~clk;

   ilk_rx_avalon_top #(.WORDS(WORDS), .LOG_WORDS(LOG_WORDS)) dut_i (.*);

   // direct checks plus whatever the bound assertions caught
   function automatic int all_errors();
      return tb_errors + int'(dut_i.asserts_i.fail_count);
   endfunction

   function automatic ilk_avl_pkg::count_t read_count(input string name);
      if (name == "pkt_count") return pkt_count;
      if (name == "err_count") return err_count;
      if (name == "drop_count") return drop_count;
      return trunc_count;
   endfunction

   task automatic check_value(input string name, input longint exp, input longint act);
      if (exp != act) begin
         $display("[FAIL] %0t: %s expected %0d, got %0d", $time, name, exp, act);
         tb_errors++;
      end
   endtask

   // one beat, held until the next falling edge
   task automatic drive_beat(input logic sop, input int num, input ilk_avl_pkg::eopbits_t code);
      @(negedge clk);
      ilk_valid     = 1'b1;
      ilk_sop       = sop;
      ilk_num_valid = LOG_WORDS'(num);
      ilk_eopbits   = code;
      for (int i = 0; i < WORDS * 2; i++) begin
         ilk_data[i*32 +: 32] = $random(seed);
      end
   endtask

   task automatic drive_idle();
      @(negedge clk);
      ilk_valid     = 1'b0;
      ilk_sop       = 1'b0;
      ilk_num_valid = '0;
      ilk_eopbits   = ilk_avl_pkg::EOP_NONE;
   endtask

   // counters trail the input by two edges
   task automatic settle();
      repeat (3) drive_idle();
   endtask

   task automatic wait_for_count(input string name, input ilk_avl_pkg::count_t exp);
      int n;
      n = 0;
      while (read_count(name) != exp && n < LIMIT) begin
         drive_idle();
         n++;
      end
      if (read_count(name) != exp) begin
         $display("timeout: %s did not reach %0d within %0d cycles", name, exp, LIMIT);
      end
      check_value(name, exp, read_count(name));
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (all_errors() != errs_at_start) begin
         tests_failed++;
         $display("test %s: FAIL", name);
      end else begin
         $display("test %s: PASS", name);
      end
      errs_at_start = all_errors();
   endtask

   initial begin
      ilk_avl_pkg::eopbits_t last;
      ilk_avl_pkg::count_t   base0;
      ilk_avl_pkg::count_t   base1;
      int                    n_err;
      arst_n        = 1'b0;
      ilk_valid     = 1'b0;
      ilk_data      = '0;
      ilk_num_valid = '0;
      ilk_sop       = 1'b0;
      ilk_eopbits   = ilk_avl_pkg::EOP_NONE;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;

      @(negedge clk);
      check_value("avl_valid", 0, avl_valid);
      check_value("avl_eop", 0, avl_eop);
      check_value("avl_error", 0, avl_error);
      check_value("pkt_count", 0, pkt_count);
      check_value("err_count", 0, err_count);
      check_value("drop_count", 0, drop_count);
      check_value("trunc_count", 0, trunc_count);
      end_test("reset");

      // every code with every count, packet opened first
      for (int code = 0; code < 16; code++) begin
         for (int cnt = 0; cnt < 4; cnt++) begin
            drive_beat(1'b1, WORDS, ilk_avl_pkg::EOP_NONE);
            drive_beat(1'b0, cnt, ilk_avl_pkg::eopbits_t'(code));
         end
      end
      drive_beat(1'b1, WORDS, ilk_avl_pkg::EOP_FLAG);  // leaves the stage idle
      settle();
      end_test("decode");

      base0 = pkt_count;
      base1 = err_count;
      n_err = 0;
      for (int p = 0; p < 24; p++) begin
         int len;
         len = 1 + ($random(seed) & 3);
         for (int b = 0; b < len; b++) begin
            last = ilk_avl_pkg::EOP_NONE;
            if (b == len - 1) begin
               last = ilk_avl_pkg::eopbits_t'($random(seed));
               if (last == ilk_avl_pkg::EOP_NONE) last = ilk_avl_pkg::EOP_ERR;
            end
            drive_beat(b == 0, 1 + ($random(seed) & 1), last);
            if ($random(seed) & 4) drive_idle();  // random gap
         end
         if (!last[3]) n_err++;  // err code or junk code
      end
      settle();
      wait_for_count("pkt_count", base0 + 24);
      wait_for_count("err_count", base1 + n_err);
      end_test("random_packets");

      base0 = drop_count;
      for (int k = 0; k < 6; k++) begin
         drive_beat(1'b0, 1 + ($random(seed) & 1), ilk_avl_pkg::eopbits_t'($random(seed)));
         drive_idle();
         check_value("avl_valid", 0, avl_valid);  // orphan never shows up
      end
      settle();
      wait_for_count("drop_count", base0 + 6);
      end_test("orphan_drop");

      base0 = trunc_count;
      base1 = pkt_count;
      drive_beat(1'b1, WORDS, ilk_avl_pkg::EOP_NONE);
      drive_beat(1'b1, WORDS, ilk_avl_pkg::EOP_NONE);  // restart
      drive_beat(1'b1, 1, ilk_avl_pkg::EOP_NONE);      // and again
      drive_beat(1'b0, 1, ilk_avl_pkg::EOP_FLAG | 4'd3);
      settle();
      wait_for_count("trunc_count", base0 + 2);
      wait_for_count("pkt_count", base1 + 1);
      end_test("truncation");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
               all_errors());
      if (all_errors() == 0 && tests_failed == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* project.f */
ilk_avl_pkg.sv
ilk_eop_decoder.sv
avl_frame_check.sv
ilk_rx_stats.sv
ilk_rx_avalon_top.sv
ilk_rx_avalon_asserts.sv
tb_ilk_rx_avalon.sv

/* Makefile */
# Verilator build and run of the Interlaken rx to Avalon-ST bridge

VERILATOR ?= verilator
TOP       ?= tb_ilk_rx_avalon
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
